// ==== logic/coh_cmd_noc_top.sv ====
// coherence command network slice from encoder through the hop chain to reassembly
`default_nettype none

module coh_cmd_noc_top #(
  parameter int num_lce_p   = 4,
  parameter int noc_width_p = 32
) (
  input  logic                                                   clk_i,
  input  logic                                                   reset_i,
  input  logic                                                   cmd_v_i,
  input  logic [coh_noc_pkg::lce_cmd_type_width_c-1:0]           cmd_type_i,
  input  logic [coh_noc_pkg::coh_cord_width_c-1:0]               cmd_dst_i,
  input  logic [coh_noc_pkg::lce_addr_width_c-1:0]               cmd_addr_i,
  input  logic [coh_noc_pkg::lce_data_width_c-1:0]               cmd_data_i,
  output logic                                                   busy_o,
  output logic                                                   bad_cmd_o,
  output logic [num_lce_p-1:0]                                   cmd_v_o,
  output logic [num_lce_p-1:0][coh_noc_pkg::lce_cmd_type_width_c-1:0] cmd_type_o,
  output logic [num_lce_p-1:0][coh_noc_pkg::lce_addr_width_c-1:0] cmd_addr_o,
  output logic [num_lce_p-1:0][coh_noc_pkg::lce_data_width_c-1:0] cmd_data_o
);
  import coh_noc_pkg::*;

  logic [lce_cmd_packet_width_c-1:0]      packet;
  logic [coh_len_width_c-1:0]             len;
  logic                                   legal;
  logic [num_lce_p:0]                     flit_v;      // entry k feeds hop k.
  logic [num_lce_p:0][noc_width_p-1:0]    flit;
  logic [num_lce_p-1:0]                   eject_v;
  logic [num_lce_p-1:0][noc_width_p-1:0]  eject_flit;

  lce_cmd_packet_encode #(
    .num_lce_p   (num_lce_p),
    .noc_width_p (noc_width_p)
  ) encode_i (
    .cmd_type_i (cmd_type_i),
    .cmd_dst_i  (cmd_dst_i),
    .cmd_addr_i (cmd_addr_i),
    .cmd_data_i (cmd_data_i),
    .packet_o   (packet),
    .len_o      (len),
    .legal_o    (legal)
  );

  wormhole_flit_serialize #(
    .noc_width_p (noc_width_p)
  ) serialize_i (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .cmd_v_i   (cmd_v_i),
    .packet_i  (packet),
    .len_i     (len),
    .legal_i   (legal),
    .busy_o    (busy_o),
    .bad_cmd_o (bad_cmd_o),
    .flit_v_o  (flit_v[0]),
    .flit_o    (flit[0])
  );

  // the last hop's forward side ends in flit_v[num_lce_p] and stays idle
  for (genvar k = 0; k < num_lce_p; k++) begin : g_hop
    wormhole_hop #(
      .noc_width_p (noc_width_p),
      .hop_id_p    (k)
    ) hop_i (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .flit_v_i     (flit_v[k]),
      .flit_i       (flit[k]),
      .fwd_v_o      (flit_v[k+1]),
      .fwd_flit_o   (flit[k+1]),
      .eject_v_o    (eject_v[k]),
      .eject_flit_o (eject_flit[k])
    );
  end

  wormhole_packet_assemble #(
    .num_lce_p   (num_lce_p),
    .noc_width_p (noc_width_p)
  ) assemble_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .eject_v_i    (eject_v),
    .eject_flit_i (eject_flit),
    .cmd_v_o      (cmd_v_o),
    .cmd_type_o   (cmd_type_o),
    .cmd_addr_o   (cmd_addr_o),
    .cmd_data_o   (cmd_data_o)
  );

endmodule

`default_nettype wire

// ==== logic/coh_noc_pkg.sv ====
// coherence network package with command codes, field widths and packet layout
`default_nettype none

package coh_noc_pkg;

  localparam int lce_cmd_type_width_c = 3;
  localparam int coh_cord_width_c     = 3;  // up to 8 lces.
  localparam int coh_len_width_c      = 4;  // flits after the header.
  localparam int lce_addr_width_c     = 32;
  localparam int lce_data_width_c     = 64;
  localparam int lce_uc_data_width_c  = 32; // low part kept by uc_data.

  // codes 6 and 7 are illegal
  typedef enum logic [lce_cmd_type_width_c-1:0] {
    e_lce_cmd_sync           = 3'd0,
    e_lce_cmd_set_tag        = 3'd1,
    e_lce_cmd_invalidate_tag = 3'd2,
    e_lce_cmd_writeback      = 3'd3,
    e_lce_cmd_data           = 3'd4,
    e_lce_cmd_uc_data        = 3'd5
  } lce_cmd_type_e;

  localparam int lce_cmd_payload_width_c =
    lce_cmd_type_width_c + coh_cord_width_c + lce_addr_width_c + lce_data_width_c;
  localparam int lce_cmd_packet_width_c =
    coh_cord_width_c + coh_len_width_c + lce_cmd_payload_width_c;

  // bit positions inside the packet, low bits first.
  localparam int coh_cord_lsb_c        = 0;
  localparam int coh_len_lsb_c         = coh_cord_lsb_c + coh_cord_width_c;
  localparam int lce_cmd_payload_lsb_c = coh_len_lsb_c + coh_len_width_c;
  localparam int lce_cmd_type_lsb_c    = lce_cmd_payload_lsb_c;
  localparam int lce_cmd_dst_lsb_c     = lce_cmd_type_lsb_c + lce_cmd_type_width_c;
  localparam int lce_cmd_addr_lsb_c    = lce_cmd_dst_lsb_c + coh_cord_width_c;
  localparam int lce_cmd_data_lsb_c    = lce_cmd_addr_lsb_c + lce_addr_width_c;

  // ceiling of a over b.
  function automatic int cdiv(input int a, input int b);
    return (a + b - 1) / b;
  endfunction

endpackage

`default_nettype wire

// ==== logic/lce_cmd_packet_encode.sv ====
// command encoder that forms a wormhole packet with cord, length and legality flag
`default_nettype none

module lce_cmd_packet_encode #(
  parameter int num_lce_p   = 4,
  parameter int noc_width_p = 32
) (
  input  logic [coh_noc_pkg::lce_cmd_type_width_c-1:0]   cmd_type_i,
  input  logic [coh_noc_pkg::coh_cord_width_c-1:0]       cmd_dst_i,
  input  logic [coh_noc_pkg::lce_addr_width_c-1:0]       cmd_addr_i,
  input  logic [coh_noc_pkg::lce_data_width_c-1:0]       cmd_data_i,
  output logic [coh_noc_pkg::lce_cmd_packet_width_c-1:0] packet_o,
  output logic [coh_noc_pkg::coh_len_width_c-1:0]        len_o,
  output logic                                           legal_o
);
  import coh_noc_pkg::*;

  // flits after the header for each kind of command
  localparam int cmd_len_lp =
    cdiv(lce_cmd_packet_width_c - lce_data_width_c, noc_width_p) - 1;
  localparam int data_len_lp =
    cdiv(lce_cmd_packet_width_c, noc_width_p) - 1;
  localparam int uc_data_len_lp =
    cdiv(lce_cmd_packet_width_c - (lce_data_width_c - lce_uc_data_width_c), noc_width_p) - 1;

  logic [lce_data_width_c-1:0] data_masked;
  logic                        type_known;
  logic                        dst_in_range;

  assign dst_in_range = (int'(cmd_dst_i) < num_lce_p);
  assign legal_o      = type_known & dst_in_range;

  always_comb begin
    type_known  = 1'b1;
    data_masked = cmd_data_i;
    len_o       = '0;
    case (lce_cmd_type_e'(cmd_type_i))
      e_lce_cmd_sync,
      e_lce_cmd_set_tag,
      e_lce_cmd_invalidate_tag,
      e_lce_cmd_writeback: begin
        data_masked = '0;  // no data travels.
        len_o       = coh_len_width_c'(cmd_len_lp);
      end
      e_lce_cmd_data: begin
        len_o = coh_len_width_c'(data_len_lp);
      end
      e_lce_cmd_uc_data: begin
        data_masked[lce_data_width_c-1:lce_uc_data_width_c] = '0;  // upper half is cut off.
        len_o = coh_len_width_c'(uc_data_len_lp);
      end
      default: begin
        type_known = 1'b0;
      end
    endcase
  end

  // illegal commands give an all-zero packet
  always_comb begin
    packet_o = '0;
    if (legal_o) begin
      packet_o[coh_cord_lsb_c +: coh_cord_width_c]         = cmd_dst_i;  // route by dst_id.
      packet_o[coh_len_lsb_c +: coh_len_width_c]           = len_o;
      packet_o[lce_cmd_type_lsb_c +: lce_cmd_type_width_c] = cmd_type_i;
      packet_o[lce_cmd_dst_lsb_c +: coh_cord_width_c]      = cmd_dst_i;
      packet_o[lce_cmd_addr_lsb_c +: lce_addr_width_c]     = cmd_addr_i;
      packet_o[lce_cmd_data_lsb_c +: lce_data_width_c]     = data_masked;
    end
  end

endmodule

`default_nettype wire

// ==== logic/wormhole_flit_serialize.sv ====
// packet serializer that sends a legal packet as one flit per cycle, header first
`default_nettype none

module wormhole_flit_serialize #(
  parameter int noc_width_p = 32
) (
  input  logic                                           clk_i,
  input  logic                                           reset_i,
  input  logic                                           cmd_v_i,
  input  logic [coh_noc_pkg::lce_cmd_packet_width_c-1:0] packet_i,
  input  logic [coh_noc_pkg::coh_len_width_c-1:0]        len_i,
  input  logic                                           legal_i,
  output logic                                           busy_o,
  output logic                                           bad_cmd_o,
  output logic                                           flit_v_o,
  output logic [noc_width_p-1:0]                         flit_o
);
  import coh_noc_pkg::*;

  localparam int num_flits_lp   = cdiv(lce_cmd_packet_width_c, noc_width_p);
  localparam int shift_width_lp = num_flits_lp * noc_width_p;

  logic [shift_width_lp-1:0]  shift_r;
  logic [coh_len_width_c-1:0] remain_r;  // flits left after the current one.
  logic                       busy_r;
  logic                       bad_r;
  logic                       accept;
  logic                       load;

  assign accept = cmd_v_i & ~busy_r;
  assign load   = accept & legal_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_r   <= 1'b0;
      bad_r    <= 1'b0;
      remain_r <= '0;
    end else begin
      bad_r <= accept & ~legal_i;  // one cycle pulse, nothing is sent.
      if (load) begin
        busy_r   <= 1'b1;
        remain_r <= len_i;
      end else if (busy_r) begin
        if (remain_r == '0) begin
          busy_r <= 1'b0;  // last flit goes out this cycle.
        end else begin
          remain_r <= remain_r - 1'b1;
        end
      end
    end
  end

  // lowest bits leave first
  always_ff @(posedge clk_i) begin
    if (load) begin
      shift_r <= shift_width_lp'(packet_i);
    end else if (busy_r) begin
      shift_r <= shift_r >> noc_width_p;
    end
  end

  assign busy_o    = busy_r;
  assign bad_cmd_o = bad_r;
  assign flit_v_o  = busy_r;
  assign flit_o    = shift_r[noc_width_p-1:0];

endmodule

`default_nettype wire

// ==== logic/wormhole_hop.sv ====
// wormhole chain hop that forwards or ejects whole packets by the header cord
`default_nettype none

module wormhole_hop #(
  parameter int noc_width_p = 32,
  parameter int hop_id_p    = 0
) (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   flit_v_i,
  input  logic [noc_width_p-1:0] flit_i,
  output logic                   fwd_v_o,
  output logic [noc_width_p-1:0] fwd_flit_o,
  output logic                   eject_v_o,
  output logic [noc_width_p-1:0] eject_flit_o
);
  import coh_noc_pkg::*;

  logic                       active_r;    // inside a packet body.
  logic                       to_eject_r;  // route held for the body.
  logic [coh_len_width_c-1:0] remain_r;
  logic [noc_width_p-1:0]     flit_r;
  logic                       fwd_v_r;
  logic                       eject_v_r;
  logic                       hdr_mine;
  logic [coh_len_width_c-1:0] hdr_len;
  logic                       steer_eject;

  assign hdr_mine    = (flit_i[coh_cord_lsb_c +: coh_cord_width_c]
                        == coh_cord_width_c'(hop_id_p));
  assign hdr_len     = flit_i[coh_len_lsb_c +: coh_len_width_c];
  assign steer_eject = active_r ? to_eject_r : hdr_mine;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      active_r   <= 1'b0;
      to_eject_r <= 1'b0;
      remain_r   <= '0;
      fwd_v_r    <= 1'b0;
      eject_v_r  <= 1'b0;
    end else begin
      fwd_v_r   <= flit_v_i & ~steer_eject;
      eject_v_r <= flit_v_i & steer_eject;
      if (flit_v_i) begin
        if (!active_r) begin
          // header flit opens the worm
          active_r   <= (hdr_len != '0);
          remain_r   <= hdr_len;
          to_eject_r <= hdr_mine;
        end else begin
          remain_r <= remain_r - 1'b1;
          if (remain_r == coh_len_width_c'(1)) begin
            active_r <= 1'b0;  // tail flit closes it.
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (flit_v_i) begin
      flit_r <= flit_i;
    end
  end

  assign fwd_v_o      = fwd_v_r;
  assign fwd_flit_o   = flit_r;
  assign eject_v_o    = eject_v_r;
  assign eject_flit_o = flit_r;

endmodule

`default_nettype wire

// ==== logic/wormhole_packet_assemble.sv ====
// per-destination reassembly of ejected flits into registered command outputs
`default_nettype none

module wormhole_packet_assemble #(
  parameter int num_lce_p   = 4,
  parameter int noc_width_p = 32
) (
  input  logic                                                   clk_i,
  input  logic                                                   reset_i,
  input  logic [num_lce_p-1:0]                                   eject_v_i,
  input  logic [num_lce_p-1:0][noc_width_p-1:0]                  eject_flit_i,
  output logic [num_lce_p-1:0]                                   cmd_v_o,
  output logic [num_lce_p-1:0][coh_noc_pkg::lce_cmd_type_width_c-1:0] cmd_type_o,
  output logic [num_lce_p-1:0][coh_noc_pkg::lce_addr_width_c-1:0] cmd_addr_o,
  output logic [num_lce_p-1:0][coh_noc_pkg::lce_data_width_c-1:0] cmd_data_o
);
  import coh_noc_pkg::*;

  localparam int num_flits_lp = cdiv(lce_cmd_packet_width_c, noc_width_p);
  localparam int buf_width_lp = num_flits_lp * noc_width_p;

  for (genvar k = 0; k < num_lce_p; k++) begin : g_slot
    logic [buf_width_lp-1:0]           buf_r;
    logic [buf_width_lp-1:0]           buf_n;
    logic [lce_cmd_packet_width_c-1:0] pkt_n;
    logic [coh_len_width_c-1:0]        remain_r;
    logic [coh_len_width_c-1:0]        idx_r;     // slot of the next body flit.
    logic [coh_len_width_c-1:0]        idx_n;
    logic [coh_len_width_c-1:0]        hdr_len;
    logic                              active_r;
    logic                              pkt_last;
    logic                              v_r;
    logic [lce_cmd_type_width_c-1:0]   type_r;
    logic [lce_addr_width_c-1:0]       addr_r;
    logic [lce_data_width_c-1:0]       data_r;

    assign hdr_len  = eject_flit_i[k][coh_len_lsb_c +: coh_len_width_c];
    assign idx_n    = active_r ? idx_r : '0;
    assign pkt_last = eject_v_i[k]
                      & (active_r ? (remain_r == coh_len_width_c'(1)) : (hdr_len == '0));

    // a header starts from a clean buffer, so bits never sent read as zero
    always_comb begin
      buf_n = active_r ? buf_r : '0;
      buf_n[idx_n * noc_width_p +: noc_width_p] = eject_flit_i[k];
    end

    assign pkt_n = buf_n[lce_cmd_packet_width_c-1:0];

    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        active_r <= 1'b0;
        remain_r <= '0;
        idx_r    <= '0;
        v_r      <= 1'b0;
      end else begin
        v_r <= pkt_last;  // one pulse per packet.
        if (eject_v_i[k]) begin
          if (!active_r) begin
            active_r <= (hdr_len != '0);
            remain_r <= hdr_len;
            idx_r    <= coh_len_width_c'(1);
          end else begin
            remain_r <= remain_r - 1'b1;
            idx_r    <= idx_r + 1'b1;
            if (remain_r == coh_len_width_c'(1)) begin
              active_r <= 1'b0;
            end
          end
        end
      end
    end

    always_ff @(posedge clk_i) begin
      if (eject_v_i[k]) begin
        buf_r <= buf_n;
      end
      if (pkt_last) begin
        type_r <= pkt_n[lce_cmd_type_lsb_c +: lce_cmd_type_width_c];
        addr_r <= pkt_n[lce_cmd_addr_lsb_c +: lce_addr_width_c];
        data_r <= pkt_n[lce_cmd_data_lsb_c +: lce_data_width_c];
      end
    end

    assign cmd_v_o[k]    = v_r;
    assign cmd_type_o[k] = type_r;
    assign cmd_addr_o[k] = addr_r;
    assign cmd_data_o[k] = data_r;
  end

endmodule

`default_nettype wire

// ==== sim/coh_cmd_noc_assertions.sv ====
// bound checks on the source rule, hop steering and one delivery per accepted command
`default_nettype none

module coh_cmd_noc_assertions #(
  parameter int num_lce_p = 4
) (
  input logic                                     clk_i,
  input logic                                     reset_i,
  input logic                                     cmd_v_i,
  input logic                                     busy_i,
  input logic                                     legal_i,
  input logic [coh_noc_pkg::coh_cord_width_c-1:0] cmd_dst_i,
  input logic [num_lce_p-1:0]                     fwd_v_i,
  input logic [num_lce_p-1:0]                     eject_v_i,
  input logic [num_lce_p-1:0]                     deliver_v_i
);
  import coh_noc_pkg::*;

  int failures = 0;  // failed assertions so far.

  a_no_strobe_while_busy: assert property (@(posedge clk_i) disable iff (reset_i)
    !(cmd_v_i && busy_i))
    else begin
      $error("cmd_v_i raised while busy_o is high");
      failures++;
    end

  // the chain ends at the last hop
  a_last_hop_idle: assert property (@(posedge clk_i) disable iff (reset_i)
    !fwd_v_i[num_lce_p-1])
    else begin
      $error("last hop forwarded a flit");
      failures++;
    end

  for (genvar k = 0; k < num_lce_p; k++) begin : g_dst
    logic [7:0] pending_r;  // accepted but not yet delivered.
    logic       inc;

    assign inc = cmd_v_i & ~busy_i & legal_i & (int'(cmd_dst_i) == k);

    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        pending_r <= '0;
      end else begin
        pending_r <= pending_r + inc - deliver_v_i[k];
      end
    end

    a_one_output: assert property (@(posedge clk_i) disable iff (reset_i)
      !(fwd_v_i[k] && eject_v_i[k]))
      else begin
        $error("hop %0d forwarded and ejected in one cycle", k);
        failures++;
      end

    a_once_per_cmd: assert property (@(posedge clk_i) disable iff (reset_i)
      deliver_v_i[k] |-> (pending_r != '0))
      else begin
        $error("destination %0d delivered without an accepted command", k);
        failures++;
      end
  end

endmodule

bind coh_cmd_noc_top coh_cmd_noc_assertions #(
  .num_lce_p (num_lce_p)
) assertions_i (
  .clk_i       (clk_i),
  .reset_i     (reset_i),
  .cmd_v_i     (cmd_v_i),
  .busy_i      (busy_o),
  .legal_i     (legal),
  .cmd_dst_i   (cmd_dst_i),
  .fwd_v_i     (flit_v[num_lce_p:1]),
  .eject_v_i   (eject_v),
  .deliver_v_i (cmd_v_o)
);

`default_nettype wire

// ==== sim/coh_cmd_noc_tb.sv ====
// directed testbench for the coherence command network slice with a delivery scoreboard
`default_nettype none

module coh_cmd_noc_tb;
  import coh_noc_pkg::*;

  localparam int num_lce_c      = 4;
  localparam int noc_width_c    = 32;
  localparam int packet_bits_c  = 109;
  localparam int clk_period_c   = 4;
  localparam int reset_cycles_c = 3;
  localparam int busy_limit_c   = 16;
  localparam int drain_limit_c  = 40;
  localparam int total_cmds_c   = 70;  // commands issued over all tests.
  localparam int watchdog_cycles_c =
    reset_cycles_c + total_cmds_c * 16 + 6 * drain_limit_c + 100;

  logic                                                 clk_i;
  logic                                                 reset_i;
  logic                                                 cmd_v_i;
  logic [lce_cmd_type_width_c-1:0]                      cmd_type_i;
  logic [coh_cord_width_c-1:0]                          cmd_dst_i;
  logic [lce_addr_width_c-1:0]                          cmd_addr_i;
  logic [lce_data_width_c-1:0]                          cmd_data_i;
  logic                                                 busy_o;
  logic                                                 bad_cmd_o;
  logic [num_lce_c-1:0]                                 cmd_v_o;
  logic [num_lce_c-1:0][lce_cmd_type_width_c-1:0]       cmd_type_o;
  logic [num_lce_c-1:0][lce_addr_width_c-1:0]           cmd_addr_o;
  logic [num_lce_c-1:0][lce_data_width_c-1:0]           cmd_data_o;

  int          cyc = 0;
  int          errors = 0;
  int          checks = 0;
  int          tests_run = 0;
  logic [31:0] rng_state = 32'hf79d_9293;

  // outstanding commands in issue order
  int          exp_dst_q[$];
  int          exp_due_q[$];
  logic [2:0]  exp_type_q[$];
  logic [31:0] exp_addr_q[$];
  logic [63:0] exp_data_q[$];

  coh_cmd_noc_top #(
    .num_lce_p   (num_lce_c),
    .noc_width_p (noc_width_c)
  ) coh_cmd_noc_top_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .cmd_v_i    (cmd_v_i),
    .cmd_type_i (cmd_type_i),
    .cmd_dst_i  (cmd_dst_i),
    .cmd_addr_i (cmd_addr_i),
    .cmd_data_i (cmd_data_i),
    .busy_o     (busy_o),
    .bad_cmd_o  (bad_cmd_o),
    .cmd_v_o    (cmd_v_o),
    .cmd_type_o (cmd_type_o),
    .cmd_addr_o (cmd_addr_o),
    .cmd_data_o (cmd_data_o)
  );

  initial clk_i = 1'b0;
  always #(clk_period_c / 2) clk_i = ~clk_i;

  always @(posedge clk_i) cyc <= cyc + 1;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic draw(output logic [31:0] value);
    rng_state = xorshift32(rng_state);
    value = rng_state;
  endtask

  // flits after the header, from the packet bits each type carries
  function automatic int expected_len(input logic [2:0] ctype);
    int bits;
    if (ctype == e_lce_cmd_data) begin
      bits = packet_bits_c;
    end else if (ctype == e_lce_cmd_uc_data) begin
      bits = packet_bits_c - 32;
    end else begin
      bits = packet_bits_c - 64;
    end
    return (bits + noc_width_c - 1) / noc_width_c - 1;
  endfunction

  function automatic logic [63:0] expected_data(input logic [2:0] ctype, input logic [63:0] d);
    if (ctype == e_lce_cmd_data) begin
      return d;
    end else if (ctype == e_lce_cmd_uc_data) begin
      return {32'h0, d[31:0]};
    end
    return 64'h0;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("mismatch at time %0t: %s got %0h expected %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic drop_expected(input int idx);
    exp_dst_q.delete(idx);
    exp_due_q.delete(idx);
    exp_type_q.delete(idx);
    exp_addr_q.delete(idx);
    exp_data_q.delete(idx);
  endtask

  task automatic clear_expected();
    exp_dst_q.delete();
    exp_due_q.delete();
    exp_type_q.delete();
    exp_addr_q.delete();
    exp_data_q.delete();
  endtask

  task automatic check_deliveries();
    int idx;
    for (int d = 0; d < num_lce_c; d++) begin
      if (cmd_v_o[d]) begin
        idx = -1;
        for (int i = 0; i < exp_dst_q.size(); i++) begin
          if (exp_dst_q[i] == d) begin
            idx = i;  // oldest command for this destination.
            break;
          end
        end
        checks++;
        assert (idx >= 0) else begin
          $display("error at time %0t: cmd_v_o[%0d] pulsed with nothing outstanding", $time, d);
          errors++;
        end
        if (idx >= 0) begin
          check_value($sformatf("arrival cycle of cmd_v_o[%0d]", d), cyc, exp_due_q[idx]);
          check_value($sformatf("cmd_type_o[%0d]", d), cmd_type_o[d], exp_type_q[idx]);
          check_value($sformatf("cmd_addr_o[%0d]", d), cmd_addr_o[d], exp_addr_q[idx]);
          check_value($sformatf("cmd_data_o[%0d]", d), cmd_data_o[d], exp_data_q[idx]);
          drop_expected(idx);
        end
      end
    end
    idx = 0;
    while (idx < exp_due_q.size()) begin
      checks++;
      assert (exp_due_q[idx] >= cyc) else begin
        $display("error at time %0t: command for destination %0d never arrived by cycle %0d",
                 $time, exp_dst_q[idx], exp_due_q[idx]);
        errors++;
      end
      if (exp_due_q[idx] < cyc) begin
        drop_expected(idx);
      end else begin
        idx++;
      end
    end
  endtask

  always @(negedge clk_i) begin
    if (!reset_i) begin
      check_deliveries();
    end
  end

  task automatic send_cmd(input logic [2:0] ctype, input logic [2:0] dst,
                          input logic [31:0] addr, input logic [63:0] data);
    int   waited;
    logic legal;
    waited = 0;
    while (busy_o && waited < busy_limit_c) begin
      @(posedge clk_i);
      #1;
      waited++;
    end
    checks++;
    assert (!busy_o) else begin
      $display("error at time %0t: busy_o stayed high for %0d cycles", $time, waited);
      errors++;
    end
    legal = (ctype < 3'd6) && (int'(dst) < num_lce_c);
    cmd_v_i    = 1'b1;
    cmd_type_i = ctype;
    cmd_dst_i  = dst;
    cmd_addr_i = addr;
    cmd_data_i = data;
    if (legal) begin
      exp_dst_q.push_back(int'(dst));
      exp_due_q.push_back(cyc + 3 + int'(dst) + expected_len(ctype));
      exp_type_q.push_back(ctype);
      exp_addr_q.push_back(addr);
      exp_data_q.push_back(expected_data(ctype, data));
    end
    @(posedge clk_i);
    #1;
    cmd_v_i = 1'b0;
    check_value("bad_cmd_o", bad_cmd_o, !legal);
    check_value("busy_o", busy_o, legal);
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_dst_q.size() != 0 && waited < drain_limit_c) begin
      @(posedge clk_i);
      #1;
      waited++;
    end
    checks++;
    assert (exp_dst_q.size() == 0) else begin
      $display("error at time %0t: %0d commands still outstanding after %0d cycles",
               $time, exp_dst_q.size(), waited);
      errors++;
    end
    clear_expected();
  endtask

  task automatic report_test(input string name, input int start_errors);
    tests_run++;
    $display("test %-20s done, %0d errors", name, errors - start_errors);
  endtask

  task automatic cmd_only_types();
    logic [31:0] addr;
    logic [31:0] junk;
    int          start_errors;
    start_errors = errors;
    for (int ct = 0; ct < 4; ct++) begin
      for (int d = 0; d < num_lce_c; d++) begin
        draw(addr);
        draw(junk);
        send_cmd(3'(ct), 3'(d), addr, {junk, ~junk});  // data must come out zero.
      end
    end
    wait_drain();
    report_test("cmd_only_types", start_errors);
  endtask

  task automatic data_types(input logic [2:0] ctype, input string name);
    logic [31:0] addr;
    logic [31:0] lo;
    logic [31:0] hi;
    int          start_errors;
    start_errors = errors;
    for (int d = 0; d < num_lce_c; d++) begin
      draw(addr);
      draw(lo);
      draw(hi);
      send_cmd(ctype, 3'(d), addr, {hi, lo});
    end
    wait_drain();
    report_test(name, start_errors);
  endtask

  task automatic illegal_commands();
    int start_errors;
    start_errors = errors;
    send_cmd(3'd6, 3'd0, 32'h0000_1000, 64'h1111);
    send_cmd(3'd7, 3'd2, 32'h0000_2000, 64'h2222);
    send_cmd(e_lce_cmd_data, 3'(num_lce_c), 32'h0000_3000, 64'h3333);
    send_cmd(e_lce_cmd_sync, 3'd7, 32'h0000_4000, 64'h4444);
    repeat (12) begin
      @(posedge clk_i);
      #1;
    end
    report_test("illegal_commands", start_errors);
  endtask

  task automatic random_back_to_back();
    logic [31:0] r;
    logic [31:0] addr;
    logic [31:0] lo;
    logic [31:0] hi;
    int          start_errors;
    start_errors = errors;
    for (int i = 0; i < 40; i++) begin
      draw(r);
      draw(addr);
      draw(lo);
      draw(hi);
      send_cmd(3'(r % 6), 3'((r >> 8) % num_lce_c), addr, {hi, lo});
    end
    wait_drain();
    report_test("random_back_to_back", start_errors);
  endtask

  task automatic reset_mid_packet();
    int start_errors;
    start_errors = errors;
    send_cmd(e_lce_cmd_data, 3'd3, 32'hdead_0040, 64'h0123_4567_89ab_cdef);
    @(posedge clk_i);
    #1;
    reset_i = 1'b1;  // header is one hop in, body still queued.
    clear_expected();
    repeat (reset_cycles_c) begin
      @(posedge clk_i);
      #1;
    end
    check_value("busy_o", busy_o, 0);
    check_value("bad_cmd_o", bad_cmd_o, 0);
    check_value("cmd_v_o", cmd_v_o, 0);
    check_value("flit_v", coh_cmd_noc_top_i.flit_v, 0);
    check_value("eject_v", coh_cmd_noc_top_i.eject_v, 0);
    reset_i = 1'b0;
    repeat (10) begin
      @(posedge clk_i);
      #1;
    end
    send_cmd(e_lce_cmd_uc_data, 3'd2, 32'hbeef_0080, 64'hfeed_face_cafe_f00d);
    wait_drain();
    report_test("reset_mid_packet", start_errors);
  endtask

  initial begin
    #(watchdog_cycles_c * clk_period_c);
    $display("timeout: run exceeded %0d cycles", watchdog_cycles_c);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    reset_i    = 1'b1;
    cmd_v_i    = 1'b0;
    cmd_type_i = '0;
    cmd_dst_i  = '0;
    cmd_addr_i = '0;
    cmd_data_i = '0;
    repeat (reset_cycles_c) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    cmd_only_types();
    data_types(e_lce_cmd_data, "data_full_block");
    data_types(e_lce_cmd_uc_data, "uc_data_low_half");
    illegal_commands();
    random_back_to_back();
    reset_mid_packet();
    errors += coh_cmd_noc_top_i.assertions_i.failures;  // bound checker failures.
    $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
logic/coh_noc_pkg.sv
logic/lce_cmd_packet_encode.sv
logic/wormhole_flit_serialize.sv
logic/wormhole_hop.sv
logic/wormhole_packet_assemble.sv
logic/coh_cmd_noc_top.sv
sim/coh_cmd_noc_assertions.sv
sim/coh_cmd_noc_tb.sv
